//--- all.f
+incdir+include
hdl/cce_msg_pkg.sv
hdl/cce_dir_pkg.sv
hdl/cce_cmd_if.sv
hdl/cce_hdr_fifo.sv
hdl/cce_directory.sv
hdl/cce_coh_engine.sv
hdl/cce_msg_out.sv
hdl/cce_top.sv
dv/cce_tb_clock.sv
dv/cce_checker.sv
dv/cce_tb.sv

//--- dv/cce_checker.sv
`timescale 1ns/1ps
`include "cce_settings.svh"

module cce_checker
  (input  logic                 clk_i
   , input  logic               rst_i
   , input  logic               lce_req_v_i
   , input  logic               lce_req_ready_o
   , input  logic               lce_cmd_v_o
   , input  logic               lce_cmd_ready_i
   , input  logic [1:0]         lce_cmd_type_o
   , input  cce_msg_pkg::lce_id_t lce_cmd_lce_o
   , input  cce_msg_pkg::paddr_t  lce_cmd_addr_o
   , input  logic               mem_cmd_v_o
   , input  logic               mem_cmd_ready_i
   , input  cce_msg_pkg::paddr_t  mem_cmd_addr_o
   , input  cce_msg_pkg::lce_id_t mem_cmd_lce_o
   );

  logic [15:0] accepted_cnt;
  logic [15:0] fill_cnt;

  // Requests taken in versus fills handed out
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      accepted_cnt <= '0;
      fill_cnt     <= '0;
    end else begin
      if (lce_req_v_i && lce_req_ready_o) begin
        accepted_cnt <= accepted_cnt + 1'b1;
      end
      if (lce_cmd_v_o && lce_cmd_ready_i && lce_cmd_type_o[1]) begin
        fill_cnt <= fill_cnt + 1'b1;
      end
    end
  end

  lce_cmd_hold: assert property (@(posedge clk_i) disable iff (rst_i)
    lce_cmd_v_o && !lce_cmd_ready_i |=> lce_cmd_v_o && $stable(lce_cmd_type_o)
      && $stable(lce_cmd_lce_o) && $stable(lce_cmd_addr_o))
    else $error("LCE command dropped or changed while stalled");

  mem_cmd_hold: assert property (@(posedge clk_i) disable iff (rst_i)
    mem_cmd_v_o && !mem_cmd_ready_i |=> mem_cmd_v_o && $stable(mem_cmd_addr_o)
      && $stable(mem_cmd_lce_o))
    else $error("Memory command dropped or changed while stalled");

  no_extra_fill: assert property (@(posedge clk_i) disable iff (rst_i)
    fill_cnt <= accepted_cnt)
    else $error("More fills than accepted requests");

  // FIFO entries, the one in the engine and a fill held at the output
  bounded_inflight: assert property (@(posedge clk_i) disable iff (rst_i)
    (accepted_cnt - fill_cnt) <= 16'(`CCE_REQ_FIFO_DEPTH + 2))
    else $error("More requests in flight than the design can hold");

endmodule

//--- dv/cce_tb.sv
`timescale 1ns/1ps
`include "cce_settings.svh"

module cce_tb;

  import cce_msg_pkg::*;

  logic       clk_i;
  logic       rst_i;
  logic       lce_req_v_i;
  logic       lce_req_ready_o;
  logic [9:0] lce_req_addr_i;
  logic [1:0] lce_req_lce_i;
  req_type_e  lce_req_type_i;
  logic       mem_resp_v_i;
  logic       mem_resp_ready_o;
  logic [9:0] mem_resp_addr_i;
  logic [1:0] mem_resp_lce_i;
  logic       lce_cmd_v_o;
  logic       lce_cmd_ready_i;
  logic [1:0] lce_cmd_type_o;
  logic [1:0] lce_cmd_lce_o;
  logic [9:0] lce_cmd_addr_o;
  logic       mem_cmd_v_o;
  logic       mem_cmd_ready_i;
  logic [9:0] mem_cmd_addr_o;
  logic [1:0] mem_cmd_lce_o;

  // Reference directory, state 0 I, 1 S, 2 M
  logic [1:0]  m_state [16];
  logic [3:0]  m_sharers [16];
  logic [1:0]  m_owner [16];
  logic [13:0] lce_exp_q [$];
  logic [11:0] mem_exp_q [$];
  logic [11:0] resp_q [$];
  int          resp_delay;
  logic [31:0] rng_state = 32'd82697;
  logic        stall_mode = 1'b0;
  string       test_name = "reset";
  int          errors = 0;
  int          checks = 0;
  int          reqs_issued = 0;
  int          cycles = 0;

  cce_tb_clock clock_gen (.clk_o(clk_i), .rst_o(rst_i));

  cce_top cce_top_i (.*);

  bind cce_top cce_checker checker_i
    (.clk_i(clk_i), .rst_i(rst_i)
     , .lce_req_v_i(lce_req_v_i), .lce_req_ready_o(lce_req_ready_o)
     , .lce_cmd_v_o(lce_cmd_v_o), .lce_cmd_ready_i(lce_cmd_ready_i)
     , .lce_cmd_type_o(lce_cmd_type_o), .lce_cmd_lce_o(lce_cmd_lce_o)
     , .lce_cmd_addr_o(lce_cmd_addr_o), .mem_cmd_v_o(mem_cmd_v_o)
     , .mem_cmd_ready_i(mem_cmd_ready_i), .mem_cmd_addr_o(mem_cmd_addr_o)
     , .mem_cmd_lce_o(mem_cmd_lce_o));

  function automatic logic [31:0] xorshift();
    rng_state = rng_state ^ (rng_state << 13);
    rng_state = rng_state ^ (rng_state >> 17);
    rng_state = rng_state ^ (rng_state << 5);
    return rng_state;
  endfunction

  // LCEs that must give up their copy before the fill
  function automatic logic [3:0] ref_targets(input logic [1:0] st, input logic [3:0] sh,
                                             input logic [1:0] own, input logic wr,
                                             input logic [1:0] lce);
    if (!wr) begin
      return (st == 2'd2 && own != lce) ? (4'b1 << own) : 4'b0;
    end
    return sh & ~(4'b1 << lce);
  endfunction

  task automatic check_value(input string what, input int expected, input int actual);
    checks++;
    if (expected != actual) begin
      errors++;
      $display("[FAIL] %s %s: expected %0h actual %0h", test_name, what, expected, actual);
    end
  endtask

  // Called at a falling edge, returns after the request is taken
  task automatic send_req(input logic wr, input logic [1:0] lce, input logic [9:0] addr);
    logic [3:0] blk;
    logic [3:0] tg;
    logic [9:0] baddr;
    blk   = addr[9:6];
    baddr = {blk, 6'b0};
    lce_req_v_i    = 1'b1;
    lce_req_type_i = wr ? e_req_wr : e_req_rd;
    lce_req_lce_i  = lce;
    lce_req_addr_i = addr;
    while (!lce_req_ready_o) @(negedge clk_i);
    reqs_issued++;
    tg = ref_targets(m_state[blk], m_sharers[blk], m_owner[blk], wr, lce);
    for (int i = 0; i < 4; i++) begin
      if (tg[i]) begin
        lce_exp_q.push_back({wr ? 2'd0 : 2'd1, 2'(i), baddr});
      end
    end
    mem_exp_q.push_back({baddr, lce});
    lce_exp_q.push_back({wr ? 2'd3 : 2'd2, lce, baddr});
    if (wr) begin
      m_state[blk]   = 2'd2;
      m_sharers[blk] = 4'b1 << lce;
      m_owner[blk]   = lce;
    end else begin
      m_state[blk]   = 2'd1;
      m_sharers[blk] = m_sharers[blk] | (4'b1 << lce);
    end
    @(negedge clk_i);
    lce_req_v_i = 1'b0;
  endtask

  task automatic send_random(input int n);
    logic [31:0] r;
    for (int i = 0; i < n; i++) begin
      r = xorshift();
      send_req(r[0], r[2:1], r[12:3]);
    end
  endtask

  task automatic wait_idle();
    while (lce_exp_q.size() != 0 || mem_exp_q.size() != 0 || resp_q.size() != 0
           || mem_resp_v_i) begin
      @(negedge clk_i);
    end
    repeat (3) @(negedge clk_i);
  endtask

  // Command monitor and memory request capture
  always @(posedge clk_i) begin
    logic [13:0] le;
    logic [11:0] me;
    if (!rst_i) begin
      if (lce_cmd_v_o && lce_cmd_ready_i) begin
        if (lce_exp_q.size() == 0) begin
          errors++;
          $display("LCE command arrived when none was expected in test %s", test_name);
        end else begin
          le = lce_exp_q.pop_front();
          check_value("lce_cmd_type", le[13:12], lce_cmd_type_o);
          check_value("lce_cmd_lce", le[11:10], lce_cmd_lce_o);
          check_value("lce_cmd_addr", le[9:0], lce_cmd_addr_o);
        end
      end
      if (mem_cmd_v_o && mem_cmd_ready_i) begin
        if (mem_exp_q.size() == 0) begin
          errors++;
          $display("Memory command arrived when none was expected in test %s", test_name);
        end else begin
          me = mem_exp_q.pop_front();
          check_value("mem_cmd_addr", me[11:2], mem_cmd_addr_o);
          check_value("mem_cmd_lce", me[1:0], mem_cmd_lce_o);
        end
        resp_q.push_back({mem_cmd_addr_o, mem_cmd_lce_o});
        resp_delay = xorshift() % 6;
      end
    end
  end

  // Memory responder and output back-pressure
  always @(negedge clk_i) begin
    logic [11:0] re;
    logic [31:0] r;
    mem_resp_v_i = 1'b0;
    r = stall_mode ? xorshift() : 32'hffff_ffff;
    lce_cmd_ready_i = r[4];
    mem_cmd_ready_i = r[9];
    if (resp_q.size() != 0) begin
      if (resp_delay > 0) begin
        resp_delay--;
      end else if (mem_resp_ready_o) begin
        re = resp_q.pop_front();
        mem_resp_v_i    = 1'b1;
        mem_resp_addr_i = re[11:2];
        mem_resp_lce_i  = re[1:0];
      end
    end
  end

  // Limit grows with the number of requests sent
  always @(posedge clk_i) begin
    cycles++;
    if (cycles > 200 * (reqs_issued + 1)) begin
      $display("Run stopped: no progress within %0d cycles in test %s", cycles, test_name);
      $display("Testbench failed");
      $finish;
    end
  end

  initial begin
    lce_req_v_i     = 1'b0;
    lce_req_addr_i  = '0;
    lce_req_lce_i   = '0;
    lce_req_type_i  = e_req_rd;
    mem_resp_v_i    = 1'b0;
    mem_resp_addr_i = '0;
    mem_resp_lce_i  = '0;
    lce_cmd_ready_i = 1'b1;
    mem_cmd_ready_i = 1'b1;
    resp_delay      = 0;
    for (int i = 0; i < 16; i++) begin
      m_state[i]   = 2'd0;
      m_sharers[i] = 4'b0;
      m_owner[i]   = 2'd0;
    end
    @(negedge clk_i);
    while (rst_i) @(negedge clk_i);

    check_value("lce_cmd_v_o", 0, lce_cmd_v_o);
    check_value("mem_cmd_v_o", 0, mem_cmd_v_o);
    check_value("lce_req_ready_o", 1, lce_req_ready_o);
    check_value("mem_resp_ready_o", 1, mem_resp_ready_o);

    test_name = "read_invalid";
    send_req(1'b0, 2'd1, 10'h0c5);
    wait_idle();

    test_name = "write_invalidates";
    send_req(1'b0, 2'd0, 10'h140);
    send_req(1'b0, 2'd2, 10'h148);
    send_req(1'b0, 2'd3, 10'h17f);
    send_req(1'b1, 2'd1, 10'h141);
    wait_idle();

    test_name = "downgrade";
    send_req(1'b1, 2'd2, 10'h1c0);
    send_req(1'b0, 2'd0, 10'h1c4);
    send_req(1'b1, 2'd3, 10'h1c8);
    wait_idle();

    test_name = "back_pressure";
    stall_mode = 1'b1;
    send_random(40);
    wait_idle();
    stall_mode = 1'b0;

    test_name = "random";
    send_random(300);
    wait_idle();

    $display("Checks: %0d errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("Testbench passed");
    end else begin
      $display("Testbench failed");
    end
    $finish;
  end

endmodule

//--- dv/cce_tb_clock.sv
`timescale 1ns/1ps

module cce_tb_clock
  (output logic clk_o
   , output logic rst_o
   );

  initial begin
    clk_o = 1'b0;
    forever #10 clk_o = ~clk_o;
  end

  // Reset covers two rising edges, released on a falling edge
  initial begin
    rst_o = 1'b1;
    repeat (2) @(posedge clk_o);
    @(negedge clk_o);
    rst_o = 1'b0;
  end

endmodule

//--- hdl/cce_cmd_if.sv
`timescale 1ns/1ps

interface cce_cmd_if;
  import cce_msg_pkg::*;

  // Handshake
  logic      v;
  logic      ready;

  // Command fields, held while v is high and ready is low
  cmd_type_e cmd_type;
  lce_id_t   lce;
  paddr_t    addr;

  // Engine side
  modport master
    (output v
     , output cmd_type
     , output lce
     , output addr
     , input ready
     );

  // Output formatter side
  modport slave
    (input v
     , input cmd_type
     , input lce
     , input addr
     , output ready
     );

endinterface

//--- hdl/cce_coh_engine.sv
`timescale 1ns/1ps
`include "cce_settings.svh"

module cce_coh_engine
  (input  logic                        clk_i
   , input  logic                      rst_i
   // LCE request FIFO
   , input  logic                      req_v_i
   , input  cce_msg_pkg::lce_req_hdr_t req_data_i
   , output logic                      req_yumi_o
   // Memory response FIFO
   , input  logic                      resp_v_i
   , input  cce_msg_pkg::mem_resp_hdr_t resp_data_i
   , output logic                      resp_yumi_o
   // Directory
   , output logic                      dir_r_v_o
   , output logic                      dir_w_v_o
   , output cce_msg_pkg::block_addr_t  dir_block_o
   , output cce_dir_pkg::dir_entry_t   dir_entry_o
   , input  cce_dir_pkg::dir_entry_t   dir_entry_i
   // Commands to the output side
   , cce_cmd_if.master                 cmd
   );

  import cce_msg_pkg::*;
  import cce_dir_pkg::*;

  engine_state_e state_r, state_n;

  // Miss status register
  req_type_e   mshr_type_r;
  lce_id_t     mshr_lce_r;
  block_addr_t mshr_block_r;

  lce_vec_t    inv_vec_r, inv_vec_n;
  dir_entry_t  new_entry_r, new_entry_n;
  lce_id_t     fill_lce_r;
  paddr_t      fill_addr_r;
  lce_vec_t    req_onehot;
  lce_id_t     inv_lce;
  lce_vec_t    inv_onehot;
  paddr_t      block_paddr;

  // Lowest pending LCE goes first
  function automatic lce_id_t first_lce(input lce_vec_t vec);
    lce_id_t idx;
    idx = '0;
    for (int i = $bits(lce_vec_t) - 1; i >= 0; i--) begin
      if (vec[i]) begin
        idx = lce_id_t'(i);
      end
    end
    return idx;
  endfunction

  assign req_onehot  = lce_vec_t'(1) << mshr_lce_r;
  assign inv_lce     = first_lce(inv_vec_r);
  assign inv_onehot  = lce_vec_t'(1) << inv_lce;
  assign block_paddr = {mshr_block_r, {`CCE_BLOCK_OFFSET{1'b0}}};
  assign dir_entry_o = new_entry_r;

  // Targets and next entry from the directory lookup
  always_comb begin
    inv_vec_n   = '0;
    new_entry_n = dir_entry_i;
    if (mshr_type_r == e_req_rd) begin
      if (dir_entry_i.state == e_coh_m && dir_entry_i.owner != mshr_lce_r) begin
        inv_vec_n = lce_vec_t'(1) << dir_entry_i.owner;
      end
      // Old owner keeps a shared copy
      new_entry_n.state   = e_coh_s;
      new_entry_n.sharers = dir_entry_i.sharers | req_onehot;
    end else begin
      inv_vec_n           = dir_entry_i.sharers & ~req_onehot;
      new_entry_n.state   = e_coh_m;
      new_entry_n.sharers = req_onehot;
      new_entry_n.owner   = mshr_lce_r;
    end
  end

  always_comb begin
    state_n      = state_r;
    req_yumi_o   = 1'b0;
    resp_yumi_o  = 1'b0;
    dir_r_v_o    = 1'b0;
    dir_w_v_o    = 1'b0;
    dir_block_o  = mshr_block_r;
    cmd.v        = 1'b0;
    cmd.cmd_type = e_cmd_mem_rd;
    cmd.lce      = mshr_lce_r;
    cmd.addr     = block_paddr;
    case (state_r)
      e_eng_idle: begin
        // Lookup starts with the pop
        dir_block_o = req_data_i.addr[$bits(paddr_t)-1:`CCE_BLOCK_OFFSET];
        if (req_v_i) begin
          req_yumi_o = 1'b1;
          dir_r_v_o  = 1'b1;
          state_n    = e_eng_dir_rd;
        end
      end
      e_eng_dir_rd: begin
        state_n = (inv_vec_n != '0) ? e_eng_inv : e_eng_mem_rd;
      end
      e_eng_inv: begin
        cmd.v        = 1'b1;
        cmd.cmd_type = (mshr_type_r == e_req_rd) ? e_cmd_downgrade : e_cmd_inv;
        cmd.lce      = inv_lce;
        if (cmd.ready && inv_vec_r == inv_onehot) begin
          state_n = e_eng_mem_rd;
        end
      end
      e_eng_mem_rd: begin
        cmd.v = 1'b1;
        if (cmd.ready) begin
          state_n = e_eng_mem_wait;
        end
      end
      e_eng_mem_wait: begin
        if (resp_v_i) begin
          resp_yumi_o = 1'b1;
          state_n     = e_eng_fill;
        end
      end
      e_eng_fill: begin
        cmd.v        = 1'b1;
        cmd.cmd_type = (mshr_type_r == e_req_rd) ? e_cmd_fill_s : e_cmd_fill_e;
        cmd.lce      = fill_lce_r;
        cmd.addr     = fill_addr_r;
        if (cmd.ready) begin
          state_n = e_eng_dir_wr;
        end
      end
      e_eng_dir_wr: begin
        dir_w_v_o = 1'b1;
        state_n   = e_eng_idle;
      end
      default: begin
        state_n = e_eng_idle;
      end
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      state_r   <= e_eng_idle;
      inv_vec_r <= '0;
    end else begin
      state_r <= state_n;
      if (state_r == e_eng_dir_rd) begin
        inv_vec_r <= inv_vec_n;
      end else if (state_r == e_eng_inv && cmd.ready) begin
        inv_vec_r <= inv_vec_r & ~inv_onehot;
      end
    end
  end

  // Request, pending entry and fill target
  always_ff @(posedge clk_i) begin
    if (req_yumi_o) begin
      mshr_type_r  <= req_data_i.req_type;
      mshr_lce_r   <= req_data_i.lce;
      mshr_block_r <= req_data_i.addr[$bits(paddr_t)-1:`CCE_BLOCK_OFFSET];
    end
    if (state_r == e_eng_dir_rd) begin
      new_entry_r <= new_entry_n;
    end
    if (resp_yumi_o) begin
      fill_lce_r  <= resp_data_i.lce;
      fill_addr_r <= resp_data_i.addr;
    end
  end

endmodule

//--- hdl/cce_dir_pkg.sv
`include "cce_settings.svh"

package cce_dir_pkg;

  // MSI block state
  typedef enum logic [1:0] {
    e_coh_i = 2'd0,
    e_coh_s = 2'd1,
    e_coh_m = 2'd2
  } coh_state_e;

  // One entry per block, owner only meaningful in e_coh_m
  typedef struct packed {
    coh_state_e            state;
    cce_msg_pkg::lce_vec_t sharers;
    cce_msg_pkg::lce_id_t  owner;
  } dir_entry_t;

  // Engine FSM
  typedef enum logic [2:0] {
    e_eng_idle     = 3'd0,
    e_eng_dir_rd   = 3'd1,
    e_eng_inv      = 3'd2,
    e_eng_mem_rd   = 3'd3,
    e_eng_mem_wait = 3'd4,
    e_eng_fill     = 3'd5,
    e_eng_dir_wr   = 3'd6
  } engine_state_e;

endpackage

//--- hdl/cce_directory.sv
`timescale 1ns/1ps

module cce_directory
  (input  logic                     clk_i
   , input  logic                   rst_i
   , input  logic                   r_v_i
   , input  logic                   w_v_i
   , input  cce_msg_pkg::block_addr_t block_i
   , input  cce_dir_pkg::dir_entry_t  entry_i
   , output cce_dir_pkg::dir_entry_t  entry_o
   );

  import cce_msg_pkg::*;
  import cce_dir_pkg::*;

  // One entry for every block in the address space
  localparam int num_blocks = 2 ** $bits(block_addr_t);

  localparam dir_entry_t entry_reset = '{
    state:   e_coh_i,
    sharers: '0,
    owner:   '0
  };

  dir_entry_t dir_mem [num_blocks];

  // Write port, all blocks start invalid
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      for (int i = 0; i < num_blocks; i++) begin
        dir_mem[i] <= entry_reset;
      end
    end else if (w_v_i) begin
      dir_mem[block_i] <= entry_i;
    end
  end

  // Registered read, result holds until the next read
  always_ff @(posedge clk_i) begin
    if (r_v_i) begin
      entry_o <= dir_mem[block_i];
    end
  end

endmodule

//--- hdl/cce_hdr_fifo.sv
`timescale 1ns/1ps

module cce_hdr_fifo
  #(parameter int data_width = 8
    , parameter int depth    = 2
    )
  (input  logic                  clk_i
   , input  logic                rst_i
   , input  logic                v_i
   , output logic                ready_o
   , input  logic [data_width-1:0] data_i
   , output logic                v_o
   , output logic [data_width-1:0] data_o
   , input  logic                yumi_i
   );

  localparam int ptr_width = (depth > 1) ? $clog2(depth) : 1;
  localparam int cnt_width = $clog2(depth + 1);

  logic [data_width-1:0] mem [depth];
  logic [ptr_width-1:0]  wr_ptr_r;
  logic [ptr_width-1:0]  rd_ptr_r;
  logic [cnt_width-1:0]  count_r;
  logic                  push;
  logic                  pop;

  // Wrap explicitly so any depth works
  function automatic logic [ptr_width-1:0] next_ptr(input logic [ptr_width-1:0] ptr);
    return (ptr == ptr_width'(depth - 1)) ? '0 : ptr + 1'b1;
  endfunction

  assign ready_o = (count_r != cnt_width'(depth));
  assign v_o     = (count_r != '0);
  assign data_o  = mem[rd_ptr_r];
  assign push    = v_i & ready_o;
  assign pop     = yumi_i & v_o;

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      wr_ptr_r <= '0;
      rd_ptr_r <= '0;
      count_r  <= '0;
    end else begin
      if (push) begin
        wr_ptr_r <= next_ptr(wr_ptr_r);
      end
      if (pop) begin
        rd_ptr_r <= next_ptr(rd_ptr_r);
      end
      if (push && !pop) begin
        count_r <= count_r + 1'b1;
      end else if (pop && !push) begin
        count_r <= count_r - 1'b1;
      end
    end
  end

  // Storage
  always_ff @(posedge clk_i) begin
    if (push) begin
      mem[wr_ptr_r] <= data_i;
    end
  end

endmodule

//--- hdl/cce_msg_out.sv
`timescale 1ns/1ps

module cce_msg_out
  (input  logic                         clk_i
   , input  logic                       rst_i
   , cce_cmd_if.slave                   cmd
   // LCE command channel
   , output logic                       lce_cmd_v_o
   , input  logic                       lce_cmd_ready_i
   , output cce_msg_pkg::lce_cmd_type_e lce_cmd_type_o
   , output cce_msg_pkg::lce_id_t       lce_cmd_lce_o
   , output cce_msg_pkg::paddr_t        lce_cmd_addr_o
   // Memory command channel
   , output logic                       mem_cmd_v_o
   , input  logic                       mem_cmd_ready_i
   , output cce_msg_pkg::paddr_t        mem_cmd_addr_o
   , output cce_msg_pkg::lce_id_t       mem_cmd_lce_o
   );

  import cce_msg_pkg::*;

  logic to_mem;
  logic lce_load;
  logic mem_load;

  // Steer by type, stall only the channel whose register is full
  assign to_mem    = (cmd.cmd_type == e_cmd_mem_rd);
  assign cmd.ready = to_mem ? ~mem_cmd_v_o : ~lce_cmd_v_o;
  assign lce_load  = cmd.v & cmd.ready & ~to_mem;
  assign mem_load  = cmd.v & cmd.ready & to_mem;

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      lce_cmd_v_o <= 1'b0;
      mem_cmd_v_o <= 1'b0;
    end else begin
      if (lce_load) begin
        lce_cmd_v_o <= 1'b1;
      end else if (lce_cmd_ready_i) begin
        lce_cmd_v_o <= 1'b0;
      end
      if (mem_load) begin
        mem_cmd_v_o <= 1'b1;
      end else if (mem_cmd_ready_i) begin
        mem_cmd_v_o <= 1'b0;
      end
    end
  end

  // Fields only load into an empty register, so they hold while valid
  always_ff @(posedge clk_i) begin
    if (lce_load) begin
      lce_cmd_type_o <= lce_cmd_type_e'(cmd.cmd_type[1:0]);
      lce_cmd_lce_o  <= cmd.lce;
      lce_cmd_addr_o <= cmd.addr;
    end
    if (mem_load) begin
      mem_cmd_addr_o <= cmd.addr;
      mem_cmd_lce_o  <= cmd.lce;
    end
  end

endmodule

//--- hdl/cce_msg_pkg.sv
`include "cce_settings.svh"

package cce_msg_pkg;

  // Address and LCE identifiers
  typedef logic [`CCE_PADDR_WIDTH-1:0] paddr_t;
  typedef logic [`CCE_PADDR_WIDTH-`CCE_BLOCK_OFFSET-1:0] block_addr_t;
  typedef logic [$clog2(`CCE_NUM_LCE)-1:0] lce_id_t;
  typedef logic [`CCE_NUM_LCE-1:0] lce_vec_t;

  // Request kinds from an LCE
  typedef enum logic [0:0] {
    e_req_rd = 1'b0,
    e_req_wr = 1'b1
  } req_type_e;

  // Commands issued by the engine, LCE types share the low encodings
  typedef enum logic [2:0] {
    e_cmd_inv       = 3'd0,
    e_cmd_downgrade = 3'd1,
    e_cmd_fill_s    = 3'd2,
    e_cmd_fill_e    = 3'd3,
    e_cmd_mem_rd    = 3'd4
  } cmd_type_e;

  // Command type as seen on the LCE port
  typedef enum logic [1:0] {
    e_lce_cmd_inv       = 2'd0,
    e_lce_cmd_downgrade = 2'd1,
    e_lce_cmd_fill_s    = 2'd2,
    e_lce_cmd_fill_e    = 2'd3
  } lce_cmd_type_e;

  // Buffered headers
  typedef struct packed {
    req_type_e req_type;
    lce_id_t   lce;
    paddr_t    addr;
  } lce_req_hdr_t;

  typedef struct packed {
    paddr_t  addr;
    lce_id_t lce;
  } mem_resp_hdr_t;

endpackage

//--- hdl/cce_top.sv
`timescale 1ns/1ps
`include "cce_settings.svh"

module cce_top
  (input  logic                         clk_i
   , input  logic                       rst_i
   // LCE request in
   , input  logic                       lce_req_v_i
   , output logic                       lce_req_ready_o
   , input  cce_msg_pkg::paddr_t        lce_req_addr_i
   , input  cce_msg_pkg::lce_id_t       lce_req_lce_i
   , input  cce_msg_pkg::req_type_e     lce_req_type_i
   // Memory response in
   , input  logic                       mem_resp_v_i
   , output logic                       mem_resp_ready_o
   , input  cce_msg_pkg::paddr_t        mem_resp_addr_i
   , input  cce_msg_pkg::lce_id_t       mem_resp_lce_i
   // LCE command out
   , output logic                       lce_cmd_v_o
   , input  logic                       lce_cmd_ready_i
   , output cce_msg_pkg::lce_cmd_type_e lce_cmd_type_o
   , output cce_msg_pkg::lce_id_t       lce_cmd_lce_o
   , output cce_msg_pkg::paddr_t        lce_cmd_addr_o
   // Memory command out
   , output logic                       mem_cmd_v_o
   , input  logic                       mem_cmd_ready_i
   , output cce_msg_pkg::paddr_t        mem_cmd_addr_o
   , output cce_msg_pkg::lce_id_t       mem_cmd_lce_o
   );

  import cce_msg_pkg::*;
  import cce_dir_pkg::*;

  lce_req_hdr_t  lce_req_hdr_li, lce_req_hdr_lo;
  mem_resp_hdr_t mem_resp_hdr_li, mem_resp_hdr_lo;
  logic          lce_req_v_lo, lce_req_yumi_li;
  logic          mem_resp_v_lo, mem_resp_yumi_li;
  logic          dir_r_v_li, dir_w_v_li;
  block_addr_t   dir_block_li;
  dir_entry_t    dir_entry_li, dir_entry_lo;

  cce_cmd_if cmd_if ();

  assign lce_req_hdr_li  = '{req_type: lce_req_type_i, lce: lce_req_lce_i, addr: lce_req_addr_i};
  assign mem_resp_hdr_li = '{addr: mem_resp_addr_i, lce: mem_resp_lce_i};

  // Input side
  cce_hdr_fifo
    #(.data_width($bits(lce_req_hdr_t))
      ,.depth(`CCE_REQ_FIFO_DEPTH)
      )
    lce_req_buffer
     (.clk_i(clk_i)
      ,.rst_i(rst_i)
      ,.v_i(lce_req_v_i)
      ,.ready_o(lce_req_ready_o)
      ,.data_i(lce_req_hdr_li)
      ,.v_o(lce_req_v_lo)
      ,.data_o(lce_req_hdr_lo)
      ,.yumi_i(lce_req_yumi_li)
      );

  cce_hdr_fifo
    #(.data_width($bits(mem_resp_hdr_t))
      ,.depth(`CCE_RESP_FIFO_DEPTH)
      )
    mem_resp_buffer
     (.clk_i(clk_i)
      ,.rst_i(rst_i)
      ,.v_i(mem_resp_v_i)
      ,.ready_o(mem_resp_ready_o)
      ,.data_i(mem_resp_hdr_li)
      ,.v_o(mem_resp_v_lo)
      ,.data_o(mem_resp_hdr_lo)
      ,.yumi_i(mem_resp_yumi_li)
      );

  // Processing
  cce_coh_engine
    engine
     (.clk_i(clk_i)
      ,.rst_i(rst_i)
      ,.req_v_i(lce_req_v_lo)
      ,.req_data_i(lce_req_hdr_lo)
      ,.req_yumi_o(lce_req_yumi_li)
      ,.resp_v_i(mem_resp_v_lo)
      ,.resp_data_i(mem_resp_hdr_lo)
      ,.resp_yumi_o(mem_resp_yumi_li)
      ,.dir_r_v_o(dir_r_v_li)
      ,.dir_w_v_o(dir_w_v_li)
      ,.dir_block_o(dir_block_li)
      ,.dir_entry_o(dir_entry_li)
      ,.dir_entry_i(dir_entry_lo)
      ,.cmd(cmd_if.master)
      );

  cce_directory
    directory
     (.clk_i(clk_i)
      ,.rst_i(rst_i)
      ,.r_v_i(dir_r_v_li)
      ,.w_v_i(dir_w_v_li)
      ,.block_i(dir_block_li)
      ,.entry_i(dir_entry_li)
      ,.entry_o(dir_entry_lo)
      );

  // Output side
  cce_msg_out
    message_out
     (.clk_i(clk_i)
      ,.rst_i(rst_i)
      ,.cmd(cmd_if.slave)
      ,.lce_cmd_v_o(lce_cmd_v_o)
      ,.lce_cmd_ready_i(lce_cmd_ready_i)
      ,.lce_cmd_type_o(lce_cmd_type_o)
      ,.lce_cmd_lce_o(lce_cmd_lce_o)
      ,.lce_cmd_addr_o(lce_cmd_addr_o)
      ,.mem_cmd_v_o(mem_cmd_v_o)
      ,.mem_cmd_ready_i(mem_cmd_ready_i)
      ,.mem_cmd_addr_o(mem_cmd_addr_o)
      ,.mem_cmd_lce_o(mem_cmd_lce_o)
      );

endmodule

//--- include/cce_settings.svh
`ifndef CCE_SETTINGS_SVH
`define CCE_SETTINGS_SVH

// System size

// LCEs attached to this engine
`define CCE_NUM_LCE 4

// Physical byte address
`define CCE_PADDR_WIDTH 10

// Bytes per block as a power of two
`define CCE_BLOCK_OFFSET 6

// Input buffering

// Request headers held ahead of the engine
`define CCE_REQ_FIFO_DEPTH 2

// Only one memory read is ever outstanding
`define CCE_RESP_FIFO_DEPTH 1

`endif

//--- run.sh
#!/bin/sh
# Build and run with Verilator, result taken from the log
rm -f sim.log
verilator --binary --timing --assert --top-module cce_tb -f all.f -o cce_sim > build.log 2>&1 \
  && ./obj_dir/cce_sim > sim.log 2>&1
grep -q "^Testbench passed$" sim.log && echo "PASS" || { echo "FAIL"; exit 1; }
